// ==== trap_pkg.sv ====
// Shared widths, privilege levels, CSR addresses and trap causes; imported by the trap unit RTL and testbench.
`default_nettype none

package trap_pkg;

    // One data word, used for CSR data, addresses and instructions.
    typedef logic [31:0] xlen_t;
    // Instruction address without bit 0.
    typedef logic [31:1] pc_t;
    typedef logic [11:0] csr_addr_t;
    // One bit per interrupt number.
    typedef logic [31:0] irq_vec_t;
    // Number field of mcause.
    typedef logic [4:0] cause_t;
    // Synchronous trap code from retirement.
    typedef logic [3:0] exc_code_t;

    // Only M and U are implemented.
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_t;

    // Machine CSR addresses.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Synchronous trap causes.
    localparam exc_code_t ECAUSE_IALIGN   = 4'd0;
    localparam exc_code_t ECAUSE_IACCESS  = 4'd1;
    localparam exc_code_t ECAUSE_IILLEGAL = 4'd2;
    localparam exc_code_t ECAUSE_EBREAK   = 4'd3;
    localparam exc_code_t ECAUSE_LALIGN   = 4'd4;
    localparam exc_code_t ECAUSE_LACCESS  = 4'd5;
    localparam exc_code_t ECAUSE_SALIGN   = 4'd6;
    localparam exc_code_t ECAUSE_SACCESS  = 4'd7;
    localparam exc_code_t ECAUSE_U_ECALL  = 4'd8;
    localparam exc_code_t ECAUSE_S_ECALL  = 4'd9;
    localparam exc_code_t ECAUSE_M_ECALL  = 4'd11;
    localparam exc_code_t ECAUSE_IPAGE    = 4'd12;
    localparam exc_code_t ECAUSE_LPAGE    = 4'd13;
    localparam exc_code_t ECAUSE_SPAGE    = 4'd15;

    // Bit positions inside mstatus.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;
    localparam int MSTATUS_MPP_HI   = 12;
    localparam int MSTATUS_MPRV_BIT = 17;

    // Interrupt numbers.
    localparam int IRQ_TIMER  = 7;
    localparam int IRQ_EXT_LO = 16;

    // Edges MIE must have been set before interrupts are taken.
    localparam int MIE_SETTLE = 2;

    // MXL 32, extensions A, C, I and M.
    localparam xlen_t MISA_VALUE = 32'h4000_1105;
    localparam xlen_t ARCH_ID    = 32'h0000_0000;
    localparam xlen_t IMP_ID     = 32'h0000_0210;

endpackage

`default_nettype wire

// ==== irq_sampler.sv ====
// Interrupt sampler; registers the irq lines, masks them with mie and offers the winning cause.
`timescale 1ns/100ps
`default_nettype none

module irq_sampler import trap_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [31:IRQ_EXT_LO]   irq,
    input  wire                   timer_irq,
    input  wire irq_vec_t         mie_mask,
    input  wire                   status_mie,
    output irq_vec_t              irq_pending,
    output cause_t                irq_cause,
    output logic                  irq_ready
);

    // Line vector before the register.
    irq_vec_t line_vec;
    // Pending and enabled.
    irq_vec_t masked;
    // Recent MIE values, newest in bit 0.
    logic [MIE_SETTLE-1:0] mie_hist;

    // Only the external and timer positions are wired.
    always_comb begin
        line_vec = '0;
        line_vec[31:IRQ_EXT_LO] = irq;
        line_vec[IRQ_TIMER] = timer_irq;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
            mie_hist    <= '0;
        end else begin
            irq_pending <= line_vec;
            mie_hist    <= {mie_hist[MIE_SETTLE-2:0], status_mie};
        end
    end

    assign masked = irq_pending & mie_mask;

    // Lowest number wins, so scan downwards.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // Current MIE too, so a trap that just cleared it blocks a second take.
    assign irq_ready = (irq_cause != '0) && (&mie_hist) && status_mie;

endmodule

`default_nettype wire

// ==== trap_dispatch.sv ====
// Trap dispatcher; picks interrupt, trap or mret at retirement and holds the current privilege.
`timescale 1ns/100ps
`default_nettype none

module trap_dispatch import trap_pkg::*; #(
    parameter bit has_u_mode = 1'b1
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             retire_valid,
    input  wire             retire_trap,
    input  wire exc_code_t  retire_cause,
    input  wire pc_t        retire_pc,
    input  wire xlen_t      retire_vaddr,
    input  wire xlen_t      retire_insn,
    input  wire             mret,
    input  wire cause_t     irq_cause,
    input  wire             irq_ready,
    input  wire priv_t      mpp,
    input  wire             mprv,
    output logic            trap_fire,
    output logic            trap_is_irq,
    output cause_t          trap_cause,
    output pc_t             trap_epc,
    output xlen_t           trap_tval,
    output logic            ret_fire,
    output priv_t           cur_priv,
    output priv_t           data_priv
);

    logic irq_take;
    logic exc_take;

    // Interrupt beats trap, trap beats mret.
    assign irq_take    = retire_valid && irq_ready;
    assign exc_take    = retire_valid && retire_trap && !irq_take;
    assign trap_fire   = irq_take || exc_take;
    assign trap_is_irq = irq_take;
    assign ret_fire    = retire_valid && mret && !trap_fire;

    assign trap_cause = irq_take ? irq_cause : {1'b0, retire_cause};
    assign trap_epc   = retire_pc;

    // mtval source per cause.
    always_comb begin
        trap_tval = '0;
        if (!irq_take) begin
            case (retire_cause)
                ECAUSE_IALIGN, ECAUSE_IACCESS, ECAUSE_IPAGE:
                    trap_tval = {retire_pc, 1'b0};
                ECAUSE_IILLEGAL:
                    trap_tval = retire_insn;
                ECAUSE_LALIGN, ECAUSE_LACCESS, ECAUSE_SALIGN, ECAUSE_SACCESS,
                ECAUSE_LPAGE, ECAUSE_SPAGE:
                    trap_tval = retire_vaddr;
                default:
                    trap_tval = '0;
            endcase
        end
    end

    generate
        if (has_u_mode) begin : g_priv_u
            // Traps enter M, mret drops to MPP.
            always_ff @(posedge clk) begin
                if (rst) begin
                    cur_priv <= PRIV_M;
                end else if (trap_fire) begin
                    cur_priv <= PRIV_M;
                end else if (ret_fire) begin
                    cur_priv <= mpp;
                end
            end
        end else begin : g_priv_m
            // Machine mode only.
            assign cur_priv = PRIV_M;
        end
    endgenerate

    // Loads and stores run at MPP while MPRV is set.
    assign data_priv = mprv ? mpp : cur_priv;

endmodule

`default_nettype wire

// ==== machine_csrs.sv ====
// Machine CSR file; holds trap state, decodes CSR reads and applies trap, return and write updates.
`timescale 1ns/100ps
`default_nettype none

module machine_csrs import trap_pkg::*; #(
    parameter xlen_t hartid     = 32'h0000_0000,
    parameter bit    has_u_mode = 1'b1
) (
    input  wire             clk,
    input  wire             rst,
    input  wire csr_addr_t  csr_addr,
    input  wire             csr_we,
    input  wire xlen_t      csr_wdata,
    input  wire             trap_fire,
    input  wire             trap_is_irq,
    input  wire cause_t     trap_cause,
    input  wire pc_t        trap_epc,
    input  wire xlen_t      trap_tval,
    input  wire             ret_fire,
    input  wire priv_t      cur_priv,
    input  wire irq_vec_t   irq_pending,
    output xlen_t           csr_rdata,
    output logic            csr_exists,
    output logic            csr_rdonly,
    output irq_vec_t        mie_mask,
    output logic            status_mie,
    output priv_t           mpp,
    output logic            mprv,
    output xlen_t           trap_vector,
    output pc_t             ret_epc
);

    // mstatus.MPIE.
    logic           status_mpie;
    // mtvec in direct mode only.
    logic [31:2]    mtvec;
    xlen_t          mscratch;
    pc_t            mepc;
    // mcause split into interrupt flag and number.
    logic           mcause_int;
    cause_t         mcause_no;
    xlen_t          mtval;

    // Composed read views.
    xlen_t          mstatus_view;
    xlen_t          mcause_view;
    xlen_t          mip_view;

    // Software writes lose against trap and return.
    logic           sw_we;

    assign sw_we = csr_we && !trap_fire && !ret_fire;

    always_comb begin
        mstatus_view = '0;
        mstatus_view[MSTATUS_MIE_BIT] = status_mie;
        mstatus_view[MSTATUS_MPIE_BIT] = status_mpie;
        mstatus_view[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mpp;
        mstatus_view[MSTATUS_MPRV_BIT] = mprv;
    end

    assign mcause_view = {mcause_int, 26'd0, mcause_no};
    // Only enabled interrupts show as pending.
    assign mip_view    = irq_pending & mie_mask;

    assign trap_vector = {mtvec, 2'b00};
    assign ret_epc     = mepc;

    // Read decode is combinational from csr_addr.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            CSR_MSTATUS:   csr_rdata = mstatus_view;
            CSR_MISA:      csr_rdata = MISA_VALUE;
            CSR_MEDELEG:   csr_rdata = '0;
            CSR_MIDELEG:   csr_rdata = '0;
            CSR_MIE:       csr_rdata = mie_mask;
            CSR_MTVEC:     csr_rdata = {mtvec, 2'b00};
            CSR_MSTATUSH:  csr_rdata = '0;
            CSR_MSCRATCH:  csr_rdata = mscratch;
            CSR_MEPC:      csr_rdata = {mepc, 1'b0};
            CSR_MCAUSE:    csr_rdata = mcause_view;
            CSR_MTVAL:     csr_rdata = mtval;
            CSR_MIP:       csr_rdata = mip_view;
            // Identity registers.
            CSR_MVENDORID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = '0;
            end
            CSR_MARCHID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = ARCH_ID;
            end
            CSR_MIMPID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = IMP_ID;
            end
            CSR_MHARTID: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            CSR_MCONFIGPTR: begin
                csr_rdonly = 1'b1;
                csr_rdata  = '0;
            end
            default: begin
                csr_exists = 1'b0;
            end
        endcase
    end

    // Core trap state.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            mie_mask    <= '0;
            mtvec       <= '0;
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_no   <= '0;
            mtval       <= '0;
        end else if (trap_fire) begin
            // Stack MIE and record the trap.
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mcause_int  <= trap_is_irq;
            mcause_no   <= trap_cause;
            mepc        <= trap_epc;
            mtval       <= trap_tval;
        end else if (ret_fire) begin
            status_mie <= status_mpie;
        end else if (sw_we) begin
            case (csr_addr)
                CSR_MSTATUS: begin
                    status_mie  <= csr_wdata[MSTATUS_MIE_BIT];
                    status_mpie <= csr_wdata[MSTATUS_MPIE_BIT];
                end
                CSR_MIE:    mie_mask <= csr_wdata;
                CSR_MTVEC:  mtvec <= csr_wdata[31:2];
                CSR_MEPC:   mepc <= csr_wdata[31:1];
                CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[31];
                    mcause_no  <= csr_wdata[4:0];
                end
                CSR_MTVAL:  mtval <= csr_wdata;
                default: begin
                end
            endcase
        end
    end

    // Scratch holds software data only.
    always_ff @(posedge clk) begin
        if (sw_we && csr_addr == CSR_MSCRATCH) begin
            mscratch <= csr_wdata;
        end
    end

    generate
        if (has_u_mode) begin : g_status_u
            // mstatus reads zero after reset.
            always_ff @(posedge clk) begin
                if (rst) begin
                    mpp  <= PRIV_U;
                    mprv <= 1'b0;
                end else if (trap_fire) begin
                    mpp <= cur_priv;
                end else if (ret_fire) begin
                    // MPRV survives only a return to M.
                    mprv <= mprv && (mpp == PRIV_M);
                end else if (sw_we && csr_addr == CSR_MSTATUS) begin
                    // Unsupported levels fold onto M.
                    if (csr_wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO] != 2'b00) begin
                        mpp <= PRIV_M;
                    end else begin
                        mpp <= PRIV_U;
                    end
                    mprv <= csr_wdata[MSTATUS_MPRV_BIT];
                end
            end
        end else begin : g_status_m
            // Without U mode MPP is tied to M.
            assign mpp  = PRIV_M;
            assign mprv = 1'b0;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== trap_unit_top.sv ====
// Trap unit top level; connects the interrupt sampler, the trap dispatcher and the CSR file.
`timescale 1ns/100ps
`default_nettype none

module trap_unit_top import trap_pkg::*; #(
    parameter xlen_t hartid     = 32'h0000_0000,
    parameter bit    has_u_mode = 1'b1
) (
    input  wire                 clk,
    input  wire                 rst,
    // Interrupt lines.
    input  wire [31:IRQ_EXT_LO] irq,
    input  wire                 timer_irq,
    // CSR access port.
    input  wire csr_addr_t      csr_addr,
    input  wire                 csr_we,
    input  wire xlen_t          csr_wdata,
    output xlen_t               csr_rdata,
    output logic                csr_exists,
    output logic                csr_rdonly,
    // Retirement.
    input  wire                 retire_valid,
    input  wire                 retire_trap,
    input  wire exc_code_t      retire_cause,
    input  wire pc_t            retire_pc,
    input  wire xlen_t          retire_vaddr,
    input  wire xlen_t          retire_insn,
    input  wire                 mret,
    // Control transfer.
    output logic                trap_fire,
    output logic                ret_fire,
    output xlen_t               trap_vector,
    output pc_t                 ret_epc,
    output priv_t               cur_priv,
    output priv_t               data_priv
);

    // Sampler to dispatcher and CSR file.
    irq_vec_t   irq_pending;
    cause_t     irq_cause;
    logic       irq_ready;
    // CSR file state fed back.
    irq_vec_t   mie_mask;
    logic       status_mie;
    priv_t      mpp;
    logic       mprv;
    // Trap record for the CSR file.
    logic       trap_is_irq;
    cause_t     trap_cause;
    pc_t        trap_epc;
    xlen_t      trap_tval;

    irq_sampler u_sampler (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .timer_irq   (timer_irq),
        .mie_mask    (mie_mask),
        .status_mie  (status_mie),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_ready   (irq_ready)
    );

    trap_dispatch #(
        .has_u_mode (has_u_mode)
    ) u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .retire_cause (retire_cause),
        .retire_pc    (retire_pc),
        .retire_vaddr (retire_vaddr),
        .retire_insn  (retire_insn),
        .mret         (mret),
        .irq_cause    (irq_cause),
        .irq_ready    (irq_ready),
        .mpp          (mpp),
        .mprv         (mprv),
        .trap_fire    (trap_fire),
        .trap_is_irq  (trap_is_irq),
        .trap_cause   (trap_cause),
        .trap_epc     (trap_epc),
        .trap_tval    (trap_tval),
        .ret_fire     (ret_fire),
        .cur_priv     (cur_priv),
        .data_priv    (data_priv)
    );

    machine_csrs #(
        .hartid     (hartid),
        .has_u_mode (has_u_mode)
    ) u_csrs (
        .clk         (clk),
        .rst         (rst),
        .csr_addr    (csr_addr),
        .csr_we      (csr_we),
        .csr_wdata   (csr_wdata),
        .trap_fire   (trap_fire),
        .trap_is_irq (trap_is_irq),
        .trap_cause  (trap_cause),
        .trap_epc    (trap_epc),
        .trap_tval   (trap_tval),
        .ret_fire    (ret_fire),
        .cur_priv    (cur_priv),
        .irq_pending (irq_pending),
        .csr_rdata   (csr_rdata),
        .csr_exists  (csr_exists),
        .csr_rdonly  (csr_rdonly),
        .mie_mask    (mie_mask),
        .status_mie  (status_mie),
        .mpp         (mpp),
        .mprv        (mprv),
        .trap_vector (trap_vector),
        .ret_epc     (ret_epc)
    );

endmodule

`default_nettype wire

// ==== tb_trap_tasks.svh ====
// Directed trap unit tests and their expected-value rules; included inside the testbench module.
`ifndef TB_TRAP_TASKS_SVH
`define TB_TRAP_TASKS_SVH

// mstatus as it should read for the given fields.
function automatic xlen_t status_word(input logic ie, input logic pie, input priv_t pp,
                                     input logic prv);
    xlen_t w;
    w = '0;
    w[MSTATUS_MIE_BIT] = ie;
    w[MSTATUS_MPIE_BIT] = pie;
    w[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = pp;
    w[MSTATUS_MPRV_BIT] = prv;
    return w;
endfunction

// Fetch faults give the PC, illegal gives the insn, memory faults the address.
function automatic xlen_t expected_tval(input exc_code_t cause, input xlen_t pc,
                                        input xlen_t vaddr, input xlen_t insn);
    xlen_t tval;
    tval = '0;
    if (cause == 4'd0 || cause == 4'd1 || cause == 4'd12) begin
        tval = pc;
    end else if (cause == 4'd2) begin
        tval = insn;
    end else if ((cause >= 4'd4 && cause <= 4'd7) || cause == 4'd13 || cause == 4'd15) begin
        tval = vaddr;
    end
    return tval;
endfunction

task automatic start_retire(input logic trap, input exc_code_t cause, input xlen_t pc,
                            input xlen_t vaddr, input xlen_t insn, input logic is_mret);
    next_cycle();
    retire_valid = 1'b1;
    retire_trap  = trap;
    retire_cause = cause;
    retire_pc    = pc[31:1];
    retire_vaddr = vaddr;
    retire_insn  = insn;
    mret         = is_mret;
endtask

// Samples the fire strobes mid-cycle, then lets the edge commit.
task automatic finish_retire(output logic fired, output logic returned);
    #10;
    fired    = trap_fire;
    returned = ret_fire;
    next_cycle();
    retire_valid = 1'b0;
    retire_trap  = 1'b0;
    mret         = 1'b0;
    csr_we       = 1'b0;
endtask

task automatic test_reset_state();
    check_eq(xlen_t'(cur_priv), xlen_t'(PRIV_M), "cur_priv after reset");
    check_eq(xlen_t'(trap_fire), 0, "trap_fire after reset");
    check_eq(xlen_t'(ret_fire), 0, "ret_fire after reset");
    check_csr(CSR_MSTATUS, 0, "mstatus after reset");
    check_csr(CSR_MIE, 0, "mie after reset");
    check_csr(CSR_MCAUSE, 0, "mcause after reset");
    check_csr(CSR_MEPC, 0, "mepc after reset");
    check_csr(CSR_MTVAL, 0, "mtval after reset");
    check_csr(CSR_MTVEC, 0, "mtvec after reset");
    check_csr(CSR_MISA, MISA_VALUE, "misa");
    check_csr(CSR_MHARTID, HARTID, "mhartid");
    check_csr(CSR_MARCHID, ARCH_ID, "marchid");
    check_csr(CSR_MIMPID, IMP_ID, "mimpid");
    check_csr(CSR_MEDELEG, 0, "medeleg");
    // Write attempt on an identity CSR.
    next_cycle();
    csr_addr  = CSR_MHARTID;
    csr_wdata = $urandom;
    csr_we    = 1'b1;
    #10;
    check_eq(xlen_t'(csr_rdonly), 1, "mhartid read-only flag");
    next_cycle();
    csr_we = 1'b0;
    check_csr(CSR_MHARTID, HARTID, "mhartid after write");
    // 0x7c0 is a custom address this unit lacks.
    next_cycle();
    csr_addr = 12'h7c0;
    #10;
    check_eq(xlen_t'(csr_exists), 0, "exists flag of unknown csr");
    next_cycle();
    csr_addr = CSR_MSCRATCH;
    #10;
    check_eq(xlen_t'(csr_exists), 1, "exists flag of mscratch");
    check_eq(xlen_t'(csr_rdonly), 0, "read-only flag of mscratch");
endtask

task automatic test_read_after_write();
    xlen_t val;
    for (int i = 0; i < 4; i++) begin
        val = $urandom;
        csr_write(CSR_MSCRATCH, val);
        check_csr(CSR_MSCRATCH, val, "mscratch readback");
        val = $urandom;
        csr_write(CSR_MIE, val);
        check_csr(CSR_MIE, val, "mie readback");
        val = $urandom;
        csr_write(CSR_MTVEC, val);
        check_csr(CSR_MTVEC, val & 32'hffff_fffc, "mtvec readback");
        val = $urandom;
        csr_write(CSR_MEPC, val);
        check_csr(CSR_MEPC, val & 32'hffff_fffe, "mepc readback");
        val = $urandom;
        csr_write(CSR_MTVAL, val);
        check_csr(CSR_MTVAL, val, "mtval readback");
        val = $urandom;
        csr_write(CSR_MCAUSE, val);
        check_csr(CSR_MCAUSE, val & 32'h8000_001f, "mcause readback");
    end
    csr_write(CSR_MIE, '0);
endtask

task automatic test_sync_traps();
    exc_code_t causes [14];
    xlen_t     vec;
    xlen_t     pc;
    xlen_t     vaddr;
    xlen_t     insn;
    logic      old_ie;
    logic      fired;
    logic      returned;
    causes = '{ECAUSE_IALIGN, ECAUSE_IACCESS, ECAUSE_IILLEGAL, ECAUSE_EBREAK,
               ECAUSE_LALIGN, ECAUSE_LACCESS, ECAUSE_SALIGN, ECAUSE_SACCESS,
               ECAUSE_U_ECALL, ECAUSE_S_ECALL, ECAUSE_M_ECALL, ECAUSE_IPAGE,
               ECAUSE_LPAGE, ECAUSE_SPAGE};
    vec = $urandom & 32'hffff_fffc;
    csr_write(CSR_MTVEC, vec);
    foreach (causes[i]) begin
        // Alternate the old MIE so MPIE sees both values.
        old_ie = (i % 2) == 1;
        pc     = $urandom & 32'hffff_fffe;
        vaddr  = $urandom;
        insn   = $urandom;
        csr_write(CSR_MSTATUS, status_word(old_ie, 1'b0, PRIV_M, 1'b0));
        // Odd entries also raise mret, which the trap must win over.
        start_retire(1'b1, causes[i], pc, vaddr, insn, old_ie);
        finish_retire(fired, returned);
        check_eq(fired, 1, $sformatf("trap_fire for cause %0d", causes[i]));
        check_eq(returned, 0, $sformatf("ret_fire for cause %0d", causes[i]));
        check_eq(trap_vector, vec, "trap_vector");
        check_csr(CSR_MCAUSE, {28'd0, causes[i]}, $sformatf("mcause for cause %0d", causes[i]));
        check_csr(CSR_MEPC, pc, $sformatf("mepc for cause %0d", causes[i]));
        check_csr(CSR_MTVAL, expected_tval(causes[i], pc, vaddr, insn),
                  $sformatf("mtval for cause %0d", causes[i]));
        check_csr(CSR_MSTATUS, status_word(1'b0, old_ie, PRIV_M, 1'b0),
                  $sformatf("mstatus after cause %0d", causes[i]));
        check_eq(xlen_t'(cur_priv), xlen_t'(PRIV_M), "cur_priv after trap");
    end
endtask

task automatic test_interrupts();
    xlen_t pc;
    xlen_t pend;
    logic  fired;
    logic  returned;
    pend = (32'd1 << IRQ_TIMER) | (32'd1 << 20);
    csr_write(CSR_MIE, pend | (32'd1 << IRQ_EXT_LO));
    csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0, PRIV_M, 1'b0));
    repeat (MIE_SETTLE + 1) next_cycle();
    timer_irq = 1'b1;
    irq[20]   = 1'b1;
    next_cycle();
    check_csr(CSR_MIP, pend, "mip with timer and line 20");
    pc = $urandom & 32'hffff_fffe;
    start_retire(1'b0, ECAUSE_IALIGN, pc, $urandom, $urandom, 1'b0);
    finish_retire(fired, returned);
    check_eq(fired, 1, "trap_fire for interrupt");
    check_csr(CSR_MCAUSE, 32'h8000_0000 | IRQ_TIMER, "mcause for interrupt");
    check_csr(CSR_MEPC, pc, "mepc for interrupt");
    check_csr(CSR_MTVAL, 0, "mtval for interrupt");
    check_csr(CSR_MSTATUS, status_word(1'b0, 1'b1, PRIV_M, 1'b0), "mstatus after interrupt");
    // Interrupt against a trap in the same retirement.
    csr_write(CSR_MSTATUS, status_word(1'b1, 1'b0, PRIV_M, 1'b0));
    repeat (MIE_SETTLE + 1) next_cycle();
    pc = $urandom & 32'hffff_fffe;
    start_retire(1'b1, ECAUSE_IILLEGAL, pc, $urandom, $urandom, 1'b0);
    finish_retire(fired, returned);
    check_eq(fired, 1, "trap_fire for interrupt with trap");
    check_csr(CSR_MCAUSE, 32'h8000_0000 | IRQ_TIMER, "mcause for interrupt with trap");
    check_csr(CSR_MTVAL, 0, "mtval for interrupt with trap");
    // Lines stay pending while MIE is clear.
    csr_write(CSR_MSTATUS, status_word(1'b0, 1'b0, PRIV_M, 1'b0));
    repeat (MIE_SETTLE + 1) next_cycle();
    start_retire(1'b0, ECAUSE_IALIGN, $urandom & 32'hffff_fffe, 0, 0, 1'b0);
    finish_retire(fired, returned);
    check_eq(fired, 0, "trap_fire with MIE clear");
    check_eq(returned, 0, "ret_fire with MIE clear");
    check_csr(CSR_MIP, pend, "mip with MIE clear");
    timer_irq = 1'b0;
    irq       = '0;
    csr_write(CSR_MIE, '0);
endtask

task automatic test_priv_return();
    xlen_t pc;
    xlen_t scratch;
    xlen_t epc;
    logic  fired;
    logic  returned;
    scratch = $urandom;
    csr_write(CSR_MSCRATCH, scratch);
    epc = $urandom & 32'hffff_fffe;
    csr_write(CSR_MEPC, epc);
    csr_write(CSR_MSTATUS, status_word(1'b0, 1'b1, PRIV_U, 1'b1));
    check_eq(xlen_t'(data_priv), xlen_t'(PRIV_U), "data_priv with MPRV set");
    check_eq(xlen_t'(cur_priv), xlen_t'(PRIV_M), "cur_priv before mret");
    check_eq({ret_epc, 1'b0}, epc, "ret_epc");
    start_retire(1'b0, ECAUSE_IALIGN, $urandom & 32'hffff_fffe, 0, 0, 1'b1);
    finish_retire(fired, returned);
    check_eq(returned, 1, "ret_fire for mret");
    check_eq(fired, 0, "trap_fire for mret");
    check_eq(xlen_t'(cur_priv), xlen_t'(PRIV_U), "cur_priv after mret");
    check_csr(CSR_MSTATUS, status_word(1'b1, 1'b1, PRIV_U, 1'b0), "mstatus after mret");
    check_eq(xlen_t'(data_priv), xlen_t'(PRIV_U), "data_priv after mret");
    // ECALL from U with a competing mscratch write.
    pc = $urandom & 32'hffff_fffe;
    start_retire(1'b1, ECAUSE_U_ECALL, pc, 0, 0, 1'b0);
    csr_addr  = CSR_MSCRATCH;
    csr_wdata = ~scratch;
    csr_we    = 1'b1;
    finish_retire(fired, returned);
    check_eq(fired, 1, "trap_fire for ecall from U");
    check_eq(xlen_t'(cur_priv), xlen_t'(PRIV_M), "cur_priv after ecall");
    check_csr(CSR_MSTATUS, status_word(1'b0, 1'b1, PRIV_U, 1'b0), "mstatus after ecall");
    check_csr(CSR_MCAUSE, 32'd8, "mcause after ecall");
    check_csr(CSR_MEPC, pc, "mepc after ecall");
    check_csr(CSR_MSCRATCH, scratch, "mscratch after write during trap");
endtask

`endif

// ==== tb_trap_unit.sv ====
// Testbench for the trap unit; drives CSR, retirement and interrupt inputs and checks the DUT.
`timescale 1ns/100ps
`default_nettype none

module tb_trap_unit import trap_pkg::*; ();

    localparam xlen_t HARTID      = 32'h0000_0005;
    localparam int    CLK_PERIOD  = 40;
    localparam int    N_TESTS     = 5;
    // Cycle budget for one directed test.
    localparam int    TEST_CYCLES = 200;

    logic                 clk;
    logic                 rst;
    logic [31:IRQ_EXT_LO] irq;
    logic                 timer_irq;
    csr_addr_t            csr_addr;
    logic                 csr_we;
    xlen_t                csr_wdata;
    xlen_t                csr_rdata;
    logic                 csr_exists;
    logic                 csr_rdonly;
    logic                 retire_valid;
    logic                 retire_trap;
    exc_code_t            retire_cause;
    pc_t                  retire_pc;
    xlen_t                retire_vaddr;
    xlen_t                retire_insn;
    logic                 mret;
    logic                 trap_fire;
    logic                 ret_fire;
    xlen_t                trap_vector;
    pc_t                  ret_epc;
    priv_t                cur_priv;
    priv_t                data_priv;

    trap_unit_top #(
        .hartid     (HARTID),
        .has_u_mode (1'b1)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .timer_irq    (timer_irq),
        .csr_addr     (csr_addr),
        .csr_we       (csr_we),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .csr_exists   (csr_exists),
        .csr_rdonly   (csr_rdonly),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .retire_cause (retire_cause),
        .retire_pc    (retire_pc),
        .retire_vaddr (retire_vaddr),
        .retire_insn  (retire_insn),
        .mret         (mret),
        .trap_fire    (trap_fire),
        .ret_fire     (ret_fire),
        .trap_vector  (trap_vector),
        .ret_epc      (ret_epc),
        .cur_priv     (cur_priv),
        .data_priv    (data_priv)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Ends a stuck run well after the tests should be done.
    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the simulation ran until %0t without finishing the tests", $time);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    task automatic check_eq(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    // Inputs change 5 ns after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // New address at the usual drive point, sampled once settled.
    task automatic csr_read(input csr_addr_t addr, output xlen_t data);
        next_cycle();
        csr_addr = addr;
        #10;
        data = csr_rdata;
    endtask

    task automatic check_csr(input csr_addr_t addr, input xlen_t exp, input string what);
        xlen_t got;
        csr_read(addr, got);
        check_eq(got, exp, what);
    endtask

    // One-cycle write strobe that commits at the edge ending it.
    task automatic csr_write(input csr_addr_t addr, input xlen_t data);
        next_cycle();
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        next_cycle();
        csr_we    = 1'b0;
    endtask

    `include "tb_trap_tasks.svh"

    initial begin
        void'($urandom(32'ha13d));
        rst          = 1'b1;
        irq          = '0;
        timer_irq    = 1'b0;
        csr_addr     = '0;
        csr_we       = 1'b0;
        csr_wdata    = '0;
        retire_valid = 1'b0;
        retire_trap  = 1'b0;
        retire_cause = '0;
        retire_pc    = '0;
        retire_vaddr = '0;
        retire_insn  = '0;
        mret         = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;

        test_reset_state();
        test_read_after_write();
        test_sync_traps();
        test_interrupts();
        test_priv_return();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
trap_pkg.sv
irq_sampler.sv
trap_dispatch.sv
machine_csrs.sv
trap_unit_top.sv
tb_trap_unit.sv

// ==== Bender.yml ====
package:
  name: trap_unit

sources:
  # RTL in dependency order.
  - trap_pkg.sv
  - irq_sampler.sv
  - trap_dispatch.sv
  - machine_csrs.sv
  - trap_unit_top.sv
  # Testbench and its task header.
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_trap_unit.sv
